// File: run.sh
#!/bin/sh
# build and run the eth_rx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module eth_rx_tb -f src.f -o eth_rx_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/eth_rx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
exit 0

// File: src.f
src/eth_rx_pkg.sv
src/eth_rx_crc.sv
src/eth_rx_frame.sv
src/eth_rx_buffer.sv
src/eth_rx_reader.sv
src/eth_rx_top.sv
test/eth_rx_chk.sv
test/eth_rx_tb.sv

// File: src/eth_rx_buffer.sv
`timescale 1ns/1ns

module eth_rx_buffer import eth_rx_pkg::*; (
   input  logic      RX_CLK,
   input  logic      wr,
   input  buf_addr_t wr_addr,
   input  byte_t     wr_data,
   input  buf_addr_t rd_addr,
   output byte_t     rd_data
);

   localparam int DEPTH = 2 ** $bits(buf_addr_t);

   byte_t mem [DEPTH];

   always_ff @(posedge RX_CLK) begin
      if (wr)
         mem[wr_addr] <= wr_data;
   end

   // registered read, one cycle latency
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// File: src/eth_rx_crc.sv
`timescale 1ns/1ns

module eth_rx_crc import eth_rx_pkg::*; (
   input  logic  RX_CLK,
   input  logic  rx_rst,
   input  logic  start,
   input  byte_t data_in,
   input  logic  data_en,
   output crc_t  crc_out
);

   // reflected ieee 802.3 polynomial
   localparam crc_t POLY = 32'hEDB88320;

   crc_t crc_q;

   // one byte, lsb first
   function automatic crc_t crc_byte(input crc_t c, input byte_t d);
      crc_t r;
      r = c;
      for (int i = 0; i < 8; i++) begin
         if (r[0] ^ d[i])
            r = (r >> 1) ^ POLY;
         else
            r = r >> 1;
      end
      return r;
   endfunction

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst)
         crc_q <= '1;
      else if (start)
         crc_q <= '1;
      else if (data_en)
         crc_q <= crc_byte(crc_q, data_in);
   end

   // bit reversed, so the residue reads in the msb-first form
   assign crc_out = {<<{crc_q}};

endmodule

// File: src/eth_rx_frame.sv
`timescale 1ns/1ns

module eth_rx_frame import eth_rx_pkg::*; #(
   parameter mac_addr_t MAC_ADDR = '0
) (
   input  logic      RX_CLK,
   input  logic      rx_rst,
   input  logic      rx_dv,
   input  nibble_t   rx_data,
   input  buf_addr_t nbytes,
   input  logic      frame_ack,
   output logic      wr,
   output buf_addr_t wr_addr,
   output byte_t     wr_data,
   output logic      frame_ok
);

   // index of the last destination address byte
   localparam buf_addr_t LAST_MAC = buf_addr_t'(5);

   rx_state_t state;
   logic      dv_q;
   logic      phase;
   nibble_t   nib_q;
   byte_t     rx_byte;
   logic      byte_done;
   mac_addr_t dest_mac;
   buf_addr_t cnt;
   buf_addr_t frame_len;
   crc_t      crc_value;

   // high nibble now, low nibble from the previous cycle
   assign rx_byte   = {rx_data, nib_q};
   assign byte_done = rx_dv && phase;
   assign frame_len = HDR_BYTES + nbytes + FCS_BYTES;

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state    <= st_idle;
         dv_q     <= 1'b0;
         phase    <= 1'b0;
         cnt      <= '0;
         wr       <= 1'b0;
         frame_ok <= 1'b0;
      end else begin
         dv_q  <= rx_dv;
         phase <= rx_dv ? ~phase : 1'b0;
         wr    <= 1'b0;

         case (state)
            st_idle: begin
               cnt <= '0;
               // joining a frame already in progress, skip it
               if (rx_dv)
                  state <= dv_q ? st_drop : st_pre;
            end

            st_pre: begin
               phase <= 1'b0;
               if (!rx_dv)
                  state <= st_idle;
               else if (rx_byte == SFD_BYTE)
                  state <= st_mac;
            end

            st_mac: begin
               if (!rx_dv) begin
                  state <= st_idle;
               end else if (phase) begin
                  wr  <= 1'b1;
                  cnt <= cnt + 1'b1;
                  if (cnt == LAST_MAC) begin
                     if ({dest_mac[39:0], rx_byte} == MAC_ADDR)
                        state <= st_body;
                     else
                        state <= st_drop;
                  end
               end
            end

            st_body: begin
               // a pending low nibble means an odd nibble count
               if (!rx_dv) begin
                  state <= phase ? st_idle : st_check;
               end else if (phase) begin
                  if (cnt == frame_len) begin
                     state <= st_drop;
                  end else begin
                     wr  <= 1'b1;
                     cnt <= cnt + 1'b1;
                  end
               end
            end

            st_check: begin
               if (cnt == frame_len && crc_value == CRC_RESIDUE) begin
                  state    <= st_done;
                  frame_ok <= 1'b1;
               end else begin
                  state <= st_idle;
               end
            end

            st_done: begin
               if (frame_ack) begin
                  frame_ok <= 1'b0;
                  state    <= st_idle;
               end
            end

            st_drop: begin
               if (!rx_dv)
                  state <= st_idle;
            end

            default: state <= st_idle;
         endcase
      end
   end

   // data path
   always_ff @(posedge RX_CLK) begin
      if (rx_dv)
         nib_q <= rx_data;
      if (byte_done) begin
         wr_addr <= cnt;
         wr_data <= rx_byte;
      end
      if (byte_done && state == st_mac)
         dest_mac <= {dest_mac[39:0], rx_byte};
   end

   // fcs is checked over every byte written after the sfd
   eth_rx_crc eth_rx_crc_inst (
      .RX_CLK  (RX_CLK),
      .rx_rst  (rx_rst),
      .start   (state == st_pre),
      .data_in (wr_data),
      .data_en (wr),
      .crc_out (crc_value)
   );

endmodule

// File: src/eth_rx_pkg.sv
package eth_rx_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  nibble_t;
   typedef logic [10:0] buf_addr_t;
   typedef logic [31:0] crc_t;
   typedef logic [47:0] mac_addr_t;

   // start of frame delimiter, low nibble 5 arrives first
   localparam byte_t SFD_BYTE = 8'hD5;

   // crc register value after a good frame including its fcs
   localparam crc_t CRC_RESIDUE = 32'hC704DD7B;

   // dest + src + type/length
   localparam buf_addr_t HDR_BYTES = 11'd14;
   localparam buf_addr_t FCS_BYTES = 11'd4;

   typedef enum logic [2:0] {
      st_idle,
      st_pre,
      st_mac,
      st_body,
      st_check,
      st_done,
      st_drop
   } rx_state_t;

endpackage

// File: src/eth_rx_reader.sv
`timescale 1ns/1ns

module eth_rx_reader import eth_rx_pkg::*; (
   input  logic      RX_CLK,
   input  logic      rx_rst,
   input  logic      frame_ok,
   input  buf_addr_t nbytes,
   output buf_addr_t rd_addr,
   input  byte_t     rd_data,
   output logic      out_valid,
   output logic      out_last,
   output byte_t     out_data,
   output logic      frame_ack
);

   logic      ok_q;
   logic      busy;
   buf_addr_t left;

   // buffer output lines up with the delayed valid
   assign out_data = rd_data;

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         ok_q      <= 1'b0;
         busy      <= 1'b0;
         left      <= '0;
         rd_addr   <= '0;
         out_valid <= 1'b0;
         out_last  <= 1'b0;
         frame_ack <= 1'b0;
      end else begin
         ok_q      <= frame_ok;
         out_valid <= busy;
         out_last  <= busy && left == buf_addr_t'(1);
         frame_ack <= out_last;

         if (frame_ok && !ok_q) begin
            // payload starts right after the header
            rd_addr <= HDR_BYTES;
            left    <= nbytes;
            if (nbytes == '0)
               frame_ack <= 1'b1;
            else
               busy <= 1'b1;
         end else if (busy) begin
            rd_addr <= rd_addr + 1'b1;
            left    <= left - 1'b1;
            if (left == buf_addr_t'(1))
               busy <= 1'b0;
         end
      end
   end

endmodule

// File: src/eth_rx_top.sv
`timescale 1ns/1ns

module eth_rx_top import eth_rx_pkg::*; #(
   parameter mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01
) (
   input  logic      RX_CLK,
   input  logic      rx_rst,
   input  logic      rx_dv,
   input  nibble_t   rx_data,
   input  buf_addr_t nbytes,
   output logic      out_valid,
   output logic      out_last,
   output byte_t     out_data,
   output logic      frame_ok
);

   logic      wr;
   buf_addr_t wr_addr;
   byte_t     wr_data;
   buf_addr_t rd_addr;
   byte_t     rd_data;
   logic      frame_ack;

   eth_rx_frame #(
      .MAC_ADDR (MAC_ADDR)
   ) eth_rx_frame_inst (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .rx_dv     (rx_dv),
      .rx_data   (rx_data),
      .nbytes    (nbytes),
      .frame_ack (frame_ack),
      .wr        (wr),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .frame_ok  (frame_ok)
   );

   eth_rx_buffer eth_rx_buffer_inst (
      .RX_CLK  (RX_CLK),
      .wr      (wr),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   eth_rx_reader eth_rx_reader_inst (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .frame_ok  (frame_ok),
      .nbytes    (nbytes),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .out_valid (out_valid),
      .out_last  (out_last),
      .out_data  (out_data),
      .frame_ack (frame_ack)
   );

endmodule

// File: test/eth_rx_chk.sv
`timescale 1ns/1ns

module eth_rx_chk import eth_rx_pkg::*; #(
   parameter bit READER_SIDE = 1'b0
) (
   input logic      RX_CLK,
   input logic      rx_rst,
   input logic      frame_ok,
   input logic      frame_ack,
   input logic      out_valid,
   input logic      wr,
   input rx_state_t state
);

   if (READER_SIDE) begin : g_reader
      // payload only streams while a good frame is held
      valid_needs_frame_ok: assert property (
         @(posedge RX_CLK) disable iff (rx_rst)
         $rose(out_valid) |-> frame_ok
      ) else $error("out_valid rose while frame_ok was low");
   end else begin : g_frame
      ack_single_cycle: assert property (
         @(posedge RX_CLK) disable iff (rx_rst)
         frame_ack |=> !frame_ack
      ) else $error("frame_ack stayed high for more than one cycle");

      // buffer is frozen while the reader owns it
      no_write_when_done: assert property (
         @(posedge RX_CLK) disable iff (rx_rst)
         state == st_done |-> !wr
      ) else $error("buffer write while the receiver holds a good frame");
   end

endmodule

// File: test/eth_rx_tb.sv
`timescale 1ns/1ns

module eth_rx_tb import eth_rx_pkg::*; ();

   localparam int        CLK_PERIOD = 4;
   localparam int        IFG_CYCLES = 24;
   localparam mac_addr_t STATION    = 48'h02_00_5E_10_20_30;
   localparam mac_addr_t OTHER_MAC  = 48'h02_00_5E_10_20_31;
   localparam mac_addr_t SRC_MAC    = 48'h02_11_22_33_44_55;

   logic      RX_CLK;
   logic      rx_rst;
   logic      rx_dv;
   nibble_t   rx_data;
   buf_addr_t nbytes;
   logic      out_valid;
   logic      out_last;
   byte_t     out_data;
   logic      frame_ok;

   // frame table, one entry per test
   string     name_q[$];
   mac_addr_t dest_q[$];
   int        len_q[$];
   bit        bad_q[$];
   bit        cut_q[$];
   bit        deliver_q[$];
   bit        table_ready = 1'b0;

   byte_t       wire_q[$];
   byte_t       payload_q[$];
   byte_t       got_data[$];
   logic        got_last[$];
   logic [31:0] rnd_state = 32'h8964;

   eth_rx_top #(
      .MAC_ADDR (STATION)
   ) eth_rx_top_inst (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .rx_dv     (rx_dv),
      .rx_data   (rx_data),
      .nbytes    (nbytes),
      .out_valid (out_valid),
      .out_last  (out_last),
      .out_data  (out_data),
      .frame_ok  (frame_ok)
   );

   bind eth_rx_frame eth_rx_chk #(
      .READER_SIDE (1'b0)
   ) frame_chk_inst (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .frame_ok  (frame_ok),
      .frame_ack (frame_ack),
      .out_valid (1'b0),
      .wr        (wr),
      .state     (state)
   );

   bind eth_rx_reader eth_rx_chk #(
      .READER_SIDE (1'b1)
   ) reader_chk_inst (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .frame_ok  (frame_ok),
      .frame_ack (frame_ack),
      .out_valid (out_valid),
      .wr        (1'b0),
      .state     (eth_rx_pkg::st_idle)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #(CLK_PERIOD / 2) RX_CLK = ~RX_CLK;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] r;
      r = x;
      r = r ^ (r << 13);
      r = r ^ (r >> 17);
      r = r ^ (r << 5);
      return r;
   endfunction

   // reflected ieee crc-32, byte xored in before the shifts
   function automatic logic [31:0] crc32_byte(input logic [31:0] c, input byte_t d);
      logic [31:0] r;
      r = c ^ {24'h0, d};
      for (int i = 0; i < 8; i++)
         r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
      return r;
   endfunction

   task automatic add_entry(input string name, input mac_addr_t dest, input int len,
                            input bit bad, input bit cut, input bit deliver);
      name_q.push_back(name);
      dest_q.push_back(dest);
      len_q.push_back(len);
      bad_q.push_back(bad);
      cut_q.push_back(cut);
      deliver_q.push_back(deliver);
   endtask

   task automatic check_value(input string test, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         $display("error: %s %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
         $display("Result: FAILED");
         $fatal(1, "mismatch in %s", test);
      end
   endtask

   task automatic build_frame(input int idx);
      logic [31:0] crc;
      wire_q.delete();
      payload_q.delete();
      for (int i = 0; i < 7; i++)
         wire_q.push_back(8'h55);
      wire_q.push_back(SFD_BYTE);
      // addresses go out most significant byte first
      for (int i = 5; i >= 0; i--)
         wire_q.push_back(dest_q[idx][8*i +: 8]);
      for (int i = 5; i >= 0; i--)
         wire_q.push_back(SRC_MAC[8*i +: 8]);
      wire_q.push_back(8'h88);
      wire_q.push_back(8'hB5);
      for (int i = 0; i < len_q[idx]; i++) begin
         rnd_state = xorshift32(rnd_state);
         payload_q.push_back(rnd_state[7:0]);
         wire_q.push_back(rnd_state[7:0]);
      end
      crc = 32'hFFFFFFFF;
      for (int i = 8; i < wire_q.size(); i++)
         crc = crc32_byte(crc, wire_q[i]);
      crc = ~crc;
      if (bad_q[idx])
         crc[15:8] = crc[15:8] ^ 8'h5A;
      for (int i = 0; i < 4; i++)
         wire_q.push_back(crc[8*i +: 8]);
   endtask

   task automatic drive_frame(input int idx);
      int stop;
      stop = wire_q.size();
      // truncated frames stop halfway through the payload
      if (cut_q[idx])
         stop = 8 + int'(HDR_BYTES) + len_q[idx] / 2;
      @(negedge RX_CLK);
      nbytes = buf_addr_t'(len_q[idx]);
      for (int i = 0; i < stop; i++) begin
         @(negedge RX_CLK);
         rx_dv   = 1'b1;
         rx_data = wire_q[i][3:0];
         @(negedge RX_CLK);
         rx_data = wire_q[i][7:4];
      end
      @(negedge RX_CLK);
      rx_dv   = 1'b0;
      rx_data = '0;
   endtask

   task automatic run_entry(input int idx);
      int expect_n;
      int waited;
      build_frame(idx);
      drive_frame(idx);
      if (deliver_q[idx]) begin
         // good frame is reported within 3 cycles of rx_dv falling
         waited = 0;
         while (!frame_ok && waited < 3) begin
            @(negedge RX_CLK);
            waited++;
         end
         check_value(name_q[idx], "frame_ok", 1, frame_ok);
         while (frame_ok)
            @(negedge RX_CLK);
      end
      repeat (IFG_CYCLES) begin
         @(negedge RX_CLK);
         check_value(name_q[idx], "frame_ok low", 0, frame_ok);
      end
      expect_n = deliver_q[idx] ? len_q[idx] : 0;
      check_value(name_q[idx], "byte count", expect_n, got_data.size());
      for (int i = 0; i < expect_n; i++) begin
         check_value(name_q[idx], $sformatf("byte %0d", i), payload_q[i], got_data[i]);
         check_value(name_q[idx], $sformatf("last flag %0d", i), i == expect_n - 1,
                     got_last[i]);
      end
      got_data.delete();
      got_last.delete();
   endtask

   // payload collector
   always @(negedge RX_CLK) begin
      if (!rx_rst && out_valid) begin
         got_data.push_back(out_data);
         got_last.push_back(out_last);
      end
   end

   initial begin
      int cycles;
      wait (table_ready);
      cycles = 100;
      for (int i = 0; i < len_q.size(); i++)
         cycles += 2 * (8 + int'(HDR_BYTES) + len_q[i] + 4) + len_q[i] + IFG_CYCLES + 40;
      #(cycles * CLK_PERIOD);
      $display("timeout: the frames were not all handled within %0d cycles", cycles);
      $display("Result: FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      rx_rst  = 1'b1;
      rx_dv   = 1'b0;
      rx_data = '0;
      nbytes  = '0;

      //        name              dest       len  bad cut deliver
      add_entry("good_60",        STATION,   60,  0,  0,  1);
      add_entry("wrong_mac",      OTHER_MAC, 20,  0,  0,  0);
      add_entry("good_after_mac", STATION,   12,  0,  0,  1);
      add_entry("bad_fcs",        STATION,   30,  1,  0,  0);
      add_entry("truncated",      STATION,   40,  0,  1,  0);
      add_entry("good_after_cut", STATION,   25,  0,  0,  1);
      add_entry("len_1",          STATION,   1,   0,  0,  1);
      add_entry("len_46",         STATION,   46,  0,  0,  1);
      add_entry("len_128",        STATION,   128, 0,  0,  1);
      table_ready = 1'b1;

      repeat (2) @(negedge RX_CLK);
      rx_rst = 1'b0;
      repeat (4) @(negedge RX_CLK);

      for (int i = 0; i < name_q.size(); i++)
         run_entry(i);

      $display("Result: PASSED");
      $finish;
   end

endmodule
